// File: pfifo_top.f
pfifo_pkg.sv
pfifo_bank.sv
pfifo_write_ctrl.sv
pfifo_status.sv
pfifo_read_ctrl.sv
pfifo_top.sv
tb_clock_gen.sv
pfifo_props.sv
tb_pfifo.sv

// File: Bender.yml
package:
  name: pfifo

sources:
  - pfifo_pkg.sv
  - pfifo_bank.sv
  - pfifo_write_ctrl.sv
  - pfifo_status.sv
  - pfifo_read_ctrl.sv
  - pfifo_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - pfifo_props.sv
      - tb_pfifo.sv

// File: tb_pfifo.sv
// single clock testbench; the writer model never writes while full, inputs move 1 ns after edges
`timescale 1ns/100ps

module tb_pfifo;

    localparam int  timeout_cyc = 200;                 // per wait loop
    localparam time stim_dly    = 1ns;
    localparam int  rng_seed    = 33;
    localparam logic [31:0] lcg_a = 32'd1103515245;
    localparam logic [31:0] lcg_c = 32'd12345;

    logic rclock;
    logic rreset;
    logic [pfifo_pkg::data_w-1:0] wdata;
    logic wsop;
    logic weop;
    logic we;
    logic re;
    logic [pfifo_pkg::word_w-1:0] rdata;
    logic rvalid;
    logic full;
    logic empty;

    logic [pfifo_pkg::word_w-1:0] sb_q[$];             // written, not yet delivered
    logic [31:0] rng_state;
    int          model_occ = 0;                        // expected words stored
    logic        exp_rvalid = 1'b0;

    tb_clock_gen u_clk (.rclock(rclock), .rreset(rreset));

    pfifo_top u_dut (
        .rclock (rclock), .rreset (rreset), .wdata (wdata), .wsop (wsop), .weop (weop),
        .we (we), .re (re), .rdata (rdata), .rvalid (rvalid), .full (full), .empty (empty)
    );

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * lcg_a + lcg_c;
        return rng_state;
    endfunction

    function automatic logic [pfifo_pkg::word_w-1:0] expected_word();
        return sb_q.pop_front();                       // oldest word first
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    task automatic tick();
        @(posedge rclock);
        #stim_dly;
    endtask

    task automatic wait_flag(input string name, input logic level);
        int cycles;
        cycles = 0;
        while (((name == "empty") ? empty : full) !== level) begin
            if (cycles == timeout_cyc) begin
                fail_run($sformatf("timed out waiting for %s to become %0d", name, level));
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    task automatic write_word(input logic sop, input logic eop, input logic [15:0] data);
        we    = 1'b1;
        wsop  = sop;
        weop  = eop;
        wdata = data;
        sb_q.push_back({sop, eop, data});              // same layout as the stored word
        tick();
    endtask

    task automatic idle_write();
        we   = 1'b0;
        wsop = 1'b0;
        weop = 1'b0;
    endtask

    task automatic write_packet(input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            write_word(i == 0, i == len - 1, r[31:16]);
        end
        idle_write();
    endtask

    task automatic read_words(input int n);
        re = 1'b1;
        repeat (n) tick();
        re = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        read_words(model_occ);                         // every stored word is accepted
        while (sb_q.size() != 0) begin
            if (cycles == timeout_cyc) begin
                fail_run("timed out waiting for the last words to be delivered");
            end else begin
                tick();
                cycles++;
            end
        end
        wait_flag("empty", 1'b1);
    endtask

    //----------------------------------------------------------------------
    // comparison, sampled mid-cycle where outputs are stable
    //----------------------------------------------------------------------
    always @(negedge rclock) begin
        if (rreset) begin
            check_val("rvalid", rvalid, exp_rvalid);
            if (rvalid && sb_q.size() == 0) begin
                fail_run("word delivered with nothing left in the scoreboard");
            end else if (rvalid) begin
                check_val("rdata", rdata, expected_word());
            end
            exp_rvalid = re && (model_occ != 0);       // accepted now, valid next cycle
            model_occ  = model_occ + int'(we) - int'(exp_rvalid);
            if (u_dut.u_props.assert_fails != 0) begin
                fail_run("a bound assertion on the FIFO internals failed");
            end
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        int cycles;
        logic [31:0] r;
        we = 1'b0;
        re = 1'b0;
        wsop = 1'b0;
        weop = 1'b0;
        wdata = '0;
        rng_state = rng_seed;
        cycles = 0;
        while (rreset !== 1'b1) begin
            if (cycles == timeout_cyc) begin
                fail_run("reset was never released");
            end else begin
                tick();
                cycles++;
            end
        end
        tick();

        // reset values
        check_val("empty", empty, 1);
        check_val("full", full, 0);
        check_val("rvalid", rvalid, 0);

        // partial packet keeps empty high
        for (int i = 0; i < 3; i++) begin
            write_word(i == 0, 1'b0, 16'h1000 + i);
        end
        idle_write();
        repeat (5) begin
            tick();
            check_val("empty", empty, 1);
        end
        write_word(1'b0, 1'b1, 16'h10ff);
        idle_write();
        wait_flag("empty", 1'b0);
        drain();

        // random length packets
        for (int p = 0; p < 20; p++) begin
            r = next_rand();
            write_packet(1 + (r[31:16] % 40));
        end
        drain();

        // two rounds across bank boundaries, second wraps past the last bank
        repeat (2) begin
            repeat (5) write_packet(600);
            drain();
        end

        // full flag
        write_packet(95);
        write_packet(4000);
        wait_flag("full", 1'b1);
        read_words(95);                                // first packet leaves
        wait_flag("full", 1'b0);
        drain();

        // read with nothing stored is ignored
        read_words(3);
        tick();
        check_val("rvalid", rvalid, 0);
        write_packet(7);
        drain();

        repeat (3) tick();
        if (u_dut.u_props.assert_fails == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("bound assertions failed during the run");
        end
    end

endmodule

// File: pfifo_props.sv
// assertions on pfifo_top internals, bound in; expects the status block instance u_status
`timescale 1ns/100ps

module pfifo_props (
    input logic                              rclock,
    input logic                              rreset,
    input logic                              rd_en,
    input logic                              rvalid,
    input logic                              empty,
    input logic [pfifo_pkg::occ_w-1:0]       occ,
    input logic [pfifo_pkg::pkt_cnt_w-1:0]   pkt_cnt
);

    int assert_fails = 0;                              // failed assertion count

    a_rvalid_follows: assert property (@(posedge rclock) disable iff (!rreset)
        rvalid == $past(rd_en))
        else begin
            $error("rvalid not one cycle after rd_en");
            assert_fails++;
        end

    a_no_read_empty: assert property (@(posedge rclock) disable iff (!rreset)
        !(rd_en && (occ == '0)))
        else begin
            $error("rd_en high with zero occupancy");
            assert_fails++;
        end

    a_occ_bound: assert property (@(posedge rclock) disable iff (!rreset)
        occ <= pfifo_pkg::occ_w'(pfifo_pkg::fifo_depth))
        else begin
            $error("occupancy above fifo depth");
            assert_fails++;
        end

    a_empty_flag: assert property (@(posedge rclock) disable iff (!rreset)
        empty == ($past(pkt_cnt) == '0))               // flag lags count by one
        else begin
            $error("empty does not match packet count");
            assert_fails++;
        end

endmodule

bind pfifo_top pfifo_props u_props (
    .rclock  (rclock),
    .rreset  (rreset),
    .rd_en   (rd_en),
    .rvalid  (rvalid),
    .empty   (empty),
    .occ     (u_status.occ),
    .pkt_cnt (u_status.pkt_cnt)
);

// File: tb_clock_gen.sv
// testbench clock of 100 ns period; reset held low for the first 4 rising edges
`timescale 1ns/100ps

module tb_clock_gen (
    output logic rclock,
    output logic rreset
);

    localparam time half_period = 50ns;                // 100 ns period
    localparam int  reset_cycles = 4;

    initial begin
        rclock = 1'b0;
        forever begin
            #half_period rclock = ~rclock;
        end
    end

    initial begin
        rreset = 1'b0;                                 // active low, asserted at start
        repeat (reset_cycles) @(posedge rclock);
        #1 rreset = 1'b1;                              // release just after an edge
    end

endmodule

// File: pfifo_top.sv
// single clock packet FIFO top; writer must honour full, empty means no whole packet stored
`timescale 1ns/100ps

module pfifo_top (
    input  logic                        rclock,
    input  logic                        rreset,
    input  logic [pfifo_pkg::data_w-1:0] wdata,
    input  logic                        wsop,
    input  logic                        weop,
    input  logic                        we,
    input  logic                        re,
    output logic [pfifo_pkg::word_w-1:0] rdata,
    output logic                        rvalid,
    output logic                        full,
    output logic                        empty
);

    logic [pfifo_pkg::word_w-1:0]    wword;            // word spread to all banks
    logic [pfifo_pkg::bank_aw-1:0]   waddr;
    logic [pfifo_pkg::bank_aw-1:0]   raddr;
    logic [pfifo_pkg::num_banks-1:0] bank_we;
    logic [pfifo_pkg::num_banks-1:0][pfifo_pkg::word_w-1:0] bank_rdata;
    logic                            rd_en;            // re qualified by occupancy
    logic                            rd_eop;

    assign wword[pfifo_pkg::sop_bit]         = wsop;
    assign wword[pfifo_pkg::eop_bit]         = weop;
    assign wword[pfifo_pkg::data_w-1:0]      = wdata;

    //------------------------------------------------------------------
    // write side
    //------------------------------------------------------------------
    pfifo_write_ctrl u_write_ctrl (
        .rclock  (rclock),
        .rreset  (rreset),
        .we      (we),
        .waddr   (waddr),
        .bank_we (bank_we)
    );

    for (genvar i = 0; i < pfifo_pkg::num_banks; i++) begin : g_bank
        pfifo_bank u_bank (
            .rclock (rclock),
            .we     (bank_we[i]),
            .waddr  (waddr),
            .wdata  (wword),
            .re     (rd_en),                           // all banks read, mux picks one
            .raddr  (raddr),
            .rdata  (bank_rdata[i])
        );
    end

    //------------------------------------------------------------------
    // read side and flags
    //------------------------------------------------------------------
    pfifo_read_ctrl u_read_ctrl (
        .rclock     (rclock),
        .rreset     (rreset),
        .rd_en      (rd_en),
        .bank_rdata (bank_rdata),
        .raddr      (raddr),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rd_eop     (rd_eop)
    );

    pfifo_status u_status (
        .rclock (rclock),
        .rreset (rreset),
        .we     (we),
        .weop   (weop),
        .re     (re),
        .rd_eop (rd_eop),
        .rd_en  (rd_en),
        .full   (full),
        .empty  (empty)
    );

endmodule

// File: pfifo_read_ctrl.sv
// read address, bank order and output mux; rd_en must already be qualified by occupancy
`timescale 1ns/100ps

module pfifo_read_ctrl (
    input  logic                        rclock,
    input  logic                        rreset,
    input  logic                        rd_en,
    input  logic [pfifo_pkg::num_banks-1:0][pfifo_pkg::word_w-1:0] bank_rdata,
    output logic [pfifo_pkg::bank_aw-1:0] raddr,
    output logic [pfifo_pkg::word_w-1:0]  rdata,
    output logic                        rvalid,
    output logic                        rd_eop
);

    logic [pfifo_pkg::bank_sel_w-1:0] rsel;            // bank being drained
    logic [pfifo_pkg::bank_sel_w-1:0] rsel_d;          // bank holding last read word
    logic                             raddr_last;

    assign raddr_last = (raddr == pfifo_pkg::bank_aw'(pfifo_pkg::bank_depth - 1));

    //------------------------------------------------------------------
    // address and bank select, same order as the write side
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            raddr <= '0;
            rsel  <= '0;
        end else if (rd_en) begin
            if (raddr_last) begin
                raddr <= '0;
                rsel  <= rsel + 1'b1;                  // step to next bank
            end else begin
                raddr <= raddr + 1'b1;
            end
        end
    end

    //------------------------------------------------------------------
    // delayed select and valid, aligned with the bank read register
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            rsel_d <= '0;
            rvalid <= 1'b0;
        end else begin
            if (rd_en) begin
                rsel_d <= rsel;                        // follows the bank just read
            end
            rvalid <= rd_en;                           // one cycle read to data
        end
    end

    assign rdata  = bank_rdata[rsel_d];                // output mux
    assign rd_eop = rvalid && rdata[pfifo_pkg::eop_bit];

endmodule

// File: pfifo_status.sv
// word and packet bookkeeping; full and empty lag their counters by one cycle
`timescale 1ns/100ps

module pfifo_status (
    input  logic rclock,
    input  logic rreset,
    input  logic we,
    input  logic weop,
    input  logic re,
    input  logic rd_eop,
    output logic rd_en,
    output logic full,
    output logic empty
);

    logic [pfifo_pkg::occ_w-1:0]     occ;              // words stored
    logic [pfifo_pkg::pkt_cnt_w-1:0] pkt_cnt;          // complete packets stored
    logic                            pkt_in;           // eop word written

    assign rd_en  = re && (occ != '0);                 // reads on an empty store are dropped
    assign pkt_in = we && weop;

    //------------------------------------------------------------------
    // word occupancy
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            occ <= '0;
        end else begin
            case ({we, rd_en})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;                   // idle or both
            endcase
        end
    end

    //------------------------------------------------------------------
    // packet count, decremented when the eop word leaves
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            pkt_cnt <= '0;
        end else begin
            case ({pkt_in, rd_eop})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;           // in and out cancel
            endcase
        end
    end

    //------------------------------------------------------------------
    // flags, registered from the counters
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            full  <= 1'b0;
            empty <= 1'b1;                             // no packet after reset
        end else begin
            full  <= (occ >= pfifo_pkg::occ_w'(pfifo_pkg::full_level));
            empty <= (pkt_cnt == '0);
        end
    end

endmodule

// File: pfifo_write_ctrl.sv
// write address and bank steering; no guard against writes while full
`timescale 1ns/100ps

module pfifo_write_ctrl (
    input  logic                           rclock,
    input  logic                           rreset,
    input  logic                           we,
    output logic [pfifo_pkg::bank_aw-1:0]   waddr,
    output logic [pfifo_pkg::num_banks-1:0] bank_we
);

    logic [pfifo_pkg::bank_sel_w-1:0] wsel;            // bank being filled
    logic                             waddr_last;      // top word of a bank

    assign waddr_last = (waddr == pfifo_pkg::bank_aw'(pfifo_pkg::bank_depth - 1));

    //------------------------------------------------------------------
    // address and bank select
    //------------------------------------------------------------------
    always_ff @(posedge rclock or negedge rreset) begin
        if (!rreset) begin
            waddr <= '0;
            wsel  <= '0;
        end else if (we) begin
            if (waddr_last) begin
                waddr <= '0;                           // wrap inside bank
                wsel  <= wsel + 1'b1;                  // next bank, 3 wraps to 0
            end else begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    //------------------------------------------------------------------
    // per bank write enable, same cycle as we
    //------------------------------------------------------------------
    always_comb begin
        bank_we       = '0;
        bank_we[wsel] = we;                            // only selected bank writes
    end

endmodule

// File: pfifo_bank.sv
// one 1k x 18 bank, behavioural RAM, read data registered and held when not reading
`timescale 1ns/100ps

module pfifo_bank (
    input  logic                         rclock,
    input  logic                         we,
    input  logic [pfifo_pkg::bank_aw-1:0] waddr,
    input  logic [pfifo_pkg::word_w-1:0]  wdata,
    input  logic                         re,
    input  logic [pfifo_pkg::bank_aw-1:0] raddr,
    output logic [pfifo_pkg::word_w-1:0]  rdata
);

    logic [pfifo_pkg::word_w-1:0] mem [pfifo_pkg::bank_depth];  // storage array

    // write port
    always_ff @(posedge rclock) begin
        if (we) begin
            mem[waddr] <= wdata;                       // sop, eop, data as one word
        end
    end

    // read port, one cycle address to data
    always_ff @(posedge rclock) begin
        if (re) begin
            rdata <= mem[raddr];
        end                                            // else keep last word
    end

endmodule

// File: pfifo_pkg.sv
// shared sizes for the 4k x 18 packet FIFO; changing depths needs matching widths below
package pfifo_pkg;

    //------------------------------------------------------------------
    // word layout
    //------------------------------------------------------------------
    localparam int data_w     = 16;                    // payload bits
    localparam int word_w     = 18;                    // sop + eop + payload
    localparam int sop_bit    = 17;                    // start of packet
    localparam int eop_bit    = 16;                    // end of packet

    //------------------------------------------------------------------
    // storage geometry
    //------------------------------------------------------------------
    localparam int bank_depth = 1024;                  // words per bank
    localparam int bank_aw    = 10;                    // log2(bank_depth)
    localparam int num_banks  = 4;
    localparam int bank_sel_w = 2;                     // log2(num_banks)
    localparam int fifo_depth = bank_depth * num_banks;

    //------------------------------------------------------------------
    // counters and flags
    //------------------------------------------------------------------
    localparam int occ_w      = 13;                    // 0 .. fifo_depth
    localparam int pkt_cnt_w  = 13;                    // worst case one packet per word
    localparam int full_level = fifo_depth - 1;        // one spare slot covers the flag lag

endpackage
